//--- hdl/axi_sram_pkg.sv
// Shared widths, memory size, burst and response codes, channel and SRAM port structs
package axi_sram_pkg;

  // ----------------------------------------------------------
  // Widths and memory geometry
  // ----------------------------------------------------------
  localparam int DATA_W    = 64;
  localparam int STRB_W    = DATA_W / 8;
  localparam int ADDR_W    = 32;
  localparam int ID_W      = 4;
  localparam int LEN_W     = 8;
  localparam int MEM_WORDS = 1024;
  localparam int IDX_W     = 10;
  localparam int OFS_W     = 3;

  // AXI burst encodings
  localparam logic [1:0] BURST_FIXED = 2'b00;
  localparam logic [1:0] BURST_INCR  = 2'b01;
  localparam logic [1:0] BURST_WRAP  = 2'b10;

  // AXI response encodings
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef logic [DATA_W-1:0] axi_data_t;
  typedef logic [STRB_W-1:0] axi_strb_t;
  typedef logic [ADDR_W-1:0] axi_addr_t;
  typedef logic [ID_W-1:0]   axi_id_t;
  // Beats minus one
  typedef logic [LEN_W-1:0]  axi_len_t;
  typedef logic [1:0]        axi_burst_t;
  typedef logic [1:0]        axi_resp_t;
  typedef logic [IDX_W-1:0]  mem_idx_t;

  // ----------------------------------------------------------
  // Channel payloads
  // ----------------------------------------------------------
  // Shared by AW and AR
  typedef struct packed {
    axi_id_t    id;
    axi_addr_t  addr;
    axi_len_t   len;
    axi_burst_t burst;
  } axi_addr_req_t;

  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
    logic      last;
  } axi_wbeat_t;

  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
  } axi_bresp_t;

  typedef struct packed {
    axi_id_t   id;
    axi_data_t data;
    axi_resp_t resp;
    logic      last;
  } axi_rbeat_t;

  // SRAM ports, en is a one-cycle strobe
  typedef struct packed {
    logic      en;
    mem_idx_t  idx;
    axi_data_t data;
    axi_strb_t strb;
  } sram_wr_t;

  typedef struct packed {
    logic     en;
    mem_idx_t idx;
  } sram_rd_t;

endpackage

//--- hdl/sram_bank.sv
// Word SRAM with byte-strobed write port and registered read-first read port
module sram_bank (
  input  logic                    i_aclk,
  input  axi_sram_pkg::sram_wr_t  i_wr,
  input  axi_sram_pkg::sram_rd_t  i_rd,
  output axi_sram_pkg::axi_data_t o_rdata
);
  import axi_sram_pkg::*;

  axi_data_t mem [MEM_WORDS];
  axi_data_t rdata_q;

  // ----------------------------------------------------------
  // Write port
  // ----------------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (i_wr.en) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (i_wr.strb[b]) begin
          mem[i_wr.idx][8*b +: 8] <= i_wr.data[8*b +: 8];
        end
      end
    end
  end

  // ----------------------------------------------------------
  // Read port
  // ----------------------------------------------------------
  // Sees the word before a same-cycle write, holds when idle
  always_ff @(posedge i_aclk) begin
    if (i_rd.en) begin
      rdata_q <= mem[i_rd.idx];
    end
  end

  assign o_rdata = rdata_q;

  // Controllers must present a clean index with every strobe
  a_wr_idx: assert property (@(posedge i_aclk)
    i_wr.en |-> !$isunknown(i_wr.idx))
    else $error("SRAM write with unknown index");

  a_rd_idx: assert property (@(posedge i_aclk)
    i_rd.en |-> !$isunknown(i_rd.idx))
    else $error("SRAM read with unknown index");

endmodule

//--- hdl/axi_sram_wr_ctrl.sv
// AXI4 write controller: AW latch, W beat counting, strobed SRAM writes, B response
module axi_sram_wr_ctrl (
  input  logic                        i_aclk,
  input  logic                        i_rst,
  input  axi_sram_pkg::axi_addr_req_t i_aw,
  input  logic                        i_awvalid,
  output logic                        o_awready,
  input  axi_sram_pkg::axi_wbeat_t    i_w,
  input  logic                        i_wvalid,
  output logic                        o_wready,
  output axi_sram_pkg::axi_bresp_t    o_b,
  output logic                        o_bvalid,
  input  logic                        i_bready,
  output axi_sram_pkg::sram_wr_t      o_sram_wr
);
  import axi_sram_pkg::*;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_t;

  wr_state_t state_q;
  axi_id_t   id_q;
  mem_idx_t  idx_q;
  axi_len_t  beats_left_q;
  logic      fixed_q;
  logic      err_q;

  logic aw_fire;
  logic w_fire;
  logic b_fire;
  logic final_beat;

  assign aw_fire    = i_awvalid & o_awready;
  assign w_fire     = i_wvalid & o_wready;
  assign b_fire     = o_bvalid & i_bready;
  // Burst end comes from len, not from WLAST
  assign final_beat = (beats_left_q == '0);

  // ----------------------------------------------------------
  // State machine
  // ----------------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      state_q <= WR_IDLE;
    end else begin
      case (state_q)
        WR_IDLE: if (aw_fire) state_q <= WR_DATA;
        WR_DATA: if (w_fire && final_beat) state_q <= WR_RESP;
        WR_RESP: if (b_fire) state_q <= WR_IDLE;
        default: state_q <= WR_IDLE;
      endcase
    end
  end

  // Request latch, beat count and word index
  always_ff @(posedge i_aclk) begin
    if (aw_fire) begin
      id_q         <= i_aw.id;
      idx_q        <= i_aw.addr[OFS_W +: IDX_W];
      beats_left_q <= i_aw.len;
      fixed_q      <= (i_aw.burst == BURST_FIXED);
      err_q        <= (i_aw.burst == BURST_WRAP);
    end else if (w_fire) begin
      beats_left_q <= beats_left_q - 1'b1;
      if (!fixed_q) begin
        idx_q <= idx_q + 1'b1;
      end
    end
  end

  assign o_awready = (state_q == WR_IDLE);
  assign o_wready  = (state_q == WR_DATA);
  assign o_bvalid  = (state_q == WR_RESP);

  assign o_b = '{id: id_q, resp: err_q ? RESP_SLVERR : RESP_OKAY};

  // WRAP beats are accepted but never reach the memory
  assign o_sram_wr = '{
    en:   w_fire & ~err_q,
    idx:  idx_q,
    data: i_w.data,
    strb: i_w.strb
  };

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------
  a_b_hold: assert property (@(posedge i_aclk) disable iff (i_rst)
    o_bvalid && !i_bready |=> o_bvalid && $stable(o_b))
    else $error("B response changed before i_bready");

  // Master's WLAST must agree with the length from AW
  a_wlast: assert property (@(posedge i_aclk) disable iff (i_rst)
    w_fire |-> (i_w.last == final_beat))
    else $error("WLAST does not match the AW burst length");

endmodule

//--- hdl/axi_sram_rd_ctrl.sv
// AXI4 read controller: AR latch, burst address stepping, R beats under back-pressure
module axi_sram_rd_ctrl (
  input  logic                        i_aclk,
  input  logic                        i_rst,
  input  axi_sram_pkg::axi_addr_req_t i_ar,
  input  logic                        i_arvalid,
  output logic                        o_arready,
  output axi_sram_pkg::axi_rbeat_t    o_r,
  output logic                        o_rvalid,
  input  logic                        i_rready,
  output axi_sram_pkg::sram_rd_t      o_sram_rd,
  input  axi_sram_pkg::axi_data_t     i_sram_rdata
);
  import axi_sram_pkg::*;

  typedef enum logic {
    RD_IDLE,
    RD_BEAT
  } rd_state_t;

  rd_state_t state_q;
  axi_id_t   id_q;
  mem_idx_t  idx_q;
  axi_len_t  len_q;
  axi_len_t  beat_q;
  logic      fixed_q;
  logic      err_q;

  logic     ar_fire;
  logic     r_fire;
  logic     last_beat;
  mem_idx_t nxt_idx;

  assign ar_fire   = i_arvalid & o_arready;
  assign r_fire    = o_rvalid & i_rready;
  assign last_beat = (beat_q == len_q);
  assign nxt_idx   = fixed_q ? idx_q : idx_q + 1'b1;

  // ----------------------------------------------------------
  // State machine
  // ----------------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      state_q <= RD_IDLE;
    end else begin
      case (state_q)
        RD_IDLE: if (ar_fire) state_q <= RD_BEAT;
        RD_BEAT: if (r_fire && last_beat) state_q <= RD_IDLE;
        default: state_q <= RD_IDLE;
      endcase
    end
  end

  // idx_q always names the word of the beat on the bus
  always_ff @(posedge i_aclk) begin
    if (ar_fire) begin
      id_q    <= i_ar.id;
      idx_q   <= i_ar.addr[OFS_W +: IDX_W];
      len_q   <= i_ar.len;
      beat_q  <= '0;
      fixed_q <= (i_ar.burst == BURST_FIXED);
      err_q   <= (i_ar.burst == BURST_WRAP);
    end else if (r_fire) begin
      idx_q  <= nxt_idx;
      beat_q <= beat_q + 1'b1;
    end
  end

  // ----------------------------------------------------------
  // SRAM read issue
  // ----------------------------------------------------------
  // First word on AR, then one word per consumed beat
  // so a stalled beat keeps its data in the bank output
  assign o_sram_rd = '{
    en:  ar_fire | (r_fire & ~last_beat),
    idx: (state_q == RD_IDLE) ? i_ar.addr[OFS_W +: IDX_W] : nxt_idx
  };

  assign o_arready = (state_q == RD_IDLE);
  assign o_rvalid  = (state_q == RD_BEAT);

  // WRAP returns zero data with SLVERR on every beat
  assign o_r = '{
    id:   id_q,
    data: err_q ? '0 : i_sram_rdata,
    resp: err_q ? RESP_SLVERR : RESP_OKAY,
    last: last_beat
  };

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------
  // Relies on the bank holding its output while no read is issued
  a_r_hold: assert property (@(posedge i_aclk) disable iff (i_rst)
    o_rvalid && !i_rready |=> o_rvalid && $stable(o_r))
    else $error("R beat changed under back-pressure");

  // Burst must end on beat len, never run past it
  a_beat_bound: assert property (@(posedge i_aclk) disable iff (i_rst)
    o_rvalid |-> (beat_q <= len_q))
    else $error("Read beat count ran past the burst length");

endmodule

//--- hdl/axi_sram_top.sv
// AXI4 SRAM slave top: write controller, read controller and shared SRAM bank
module axi_sram_top (
  input  logic                        i_aclk,
  input  logic                        i_rst,

  // Write address
  input  axi_sram_pkg::axi_addr_req_t i_aw,
  input  logic                        i_awvalid,
  output logic                        o_awready,

  // Write data
  input  axi_sram_pkg::axi_wbeat_t    i_w,
  input  logic                        i_wvalid,
  output logic                        o_wready,

  // Write response
  output axi_sram_pkg::axi_bresp_t    o_b,
  output logic                        o_bvalid,
  input  logic                        i_bready,

  // Read address
  input  axi_sram_pkg::axi_addr_req_t i_ar,
  input  logic                        i_arvalid,
  output logic                        o_arready,

  // Read data
  output axi_sram_pkg::axi_rbeat_t    o_r,
  output logic                        o_rvalid,
  input  logic                        i_rready
);
  import axi_sram_pkg::*;

  sram_wr_t  sram_wr;
  sram_rd_t  sram_rd;
  axi_data_t sram_rdata;

  // ----------------------------------------------------------
  // Write path
  // ----------------------------------------------------------
  axi_sram_wr_ctrl u_wr_ctrl (
    .i_aclk    (i_aclk),
    .i_rst     (i_rst),
    .i_aw      (i_aw),
    .i_awvalid (i_awvalid),
    .o_awready (o_awready),
    .i_w       (i_w),
    .i_wvalid  (i_wvalid),
    .o_wready  (o_wready),
    .o_b       (o_b),
    .o_bvalid  (o_bvalid),
    .i_bready  (i_bready),
    .o_sram_wr (sram_wr)
  );

  // Storage
  sram_bank u_bank (
    .i_aclk  (i_aclk),
    .i_wr    (sram_wr),
    .i_rd    (sram_rd),
    .o_rdata (sram_rdata)
  );

  // ----------------------------------------------------------
  // Read path
  // ----------------------------------------------------------
  axi_sram_rd_ctrl u_rd_ctrl (
    .i_aclk       (i_aclk),
    .i_rst        (i_rst),
    .i_ar         (i_ar),
    .i_arvalid    (i_arvalid),
    .o_arready    (o_arready),
    .o_r          (o_r),
    .o_rvalid     (o_rvalid),
    .i_rready     (i_rready),
    .o_sram_rd    (sram_rd),
    .i_sram_rdata (sram_rdata)
  );

endmodule

//--- tests/tb_axi_sram.sv
// Testbench for the AXI4 SRAM slave: clock, reset, case file reader, channel drivers, compares
module tb_axi_sram;
  import axi_sram_pkg::*;

  localparam int TIMEOUT = 1000;

  logic          aclk;
  logic          rst;
  axi_addr_req_t aw;
  logic          awvalid;
  logic          awready;
  axi_wbeat_t    w;
  logic          wvalid;
  logic          wready;
  axi_bresp_t    b;
  logic          bvalid;
  logic          bready;
  axi_addr_req_t ar;
  logic          arvalid;
  logic          arready;
  axi_rbeat_t    r;
  logic          rvalid;
  logic          rready;

  integer        seed = 32'heaf3be5d;
  integer        fd;
  integer        code;
  int            n_txn;
  logic [63:0]   kind;
  logic [8*128-1:0] line;

  // Current transaction from the case file
  axi_id_t    id;
  axi_addr_t  addr;
  axi_len_t   len;
  axi_burst_t burst;
  axi_strb_t  strb;
  axi_resp_t  resp;
  axi_data_t  words [256];

  axi_sram_top dut0 (
    .i_aclk (aclk), .i_rst (rst),
    .i_aw (aw), .i_awvalid (awvalid), .o_awready (awready),
    .i_w (w), .i_wvalid (wvalid), .o_wready (wready),
    .o_b (b), .o_bvalid (bvalid), .i_bready (bready),
    .i_ar (ar), .i_arvalid (arvalid), .o_arready (arready),
    .o_r (r), .o_rvalid (rvalid), .i_rready (rready)
  );

  initial begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;
  end

  task abort(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  // ----------------------------------------------------------
  // Compares
  // ----------------------------------------------------------
  task check_ready(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort($sformatf("error at %0t: %s expected %b, got %b", $time, name, exp, act));
    end
  endtask

  task check_bresp(input axi_bresp_t exp, input axi_bresp_t act);
    if (act !== exp) begin
      abort($sformatf("error at %0t: o_b expected id %h resp %h, got id %h resp %h",
                      $time, exp.id, exp.resp, act.id, act.resp));
    end
  endtask

  task check_rbeat(input axi_rbeat_t exp, input axi_rbeat_t act);
    if (act !== exp) begin
      abort($sformatf("error at %0t: o_r expected %h/%h/%h/%b, got %h/%h/%h/%b", $time,
                      exp.id, exp.data, exp.resp, exp.last, act.id, act.data, act.resp,
                      act.last));
    end
  endtask

  // One falling edge, fresh random readies, bounded by the timeout
  task next_cycle(input string name, inout int cnt);
    logic [31:0] rnd;
    @(negedge aclk);
    rnd = $random(seed);
    bready = rnd[0];
    rnd = $random(seed);
    rready = rnd[0];
    cnt++;
    if (cnt > TIMEOUT) begin
      abort({name, " handshake never completed"});
    end
  endtask

  // ----------------------------------------------------------
  // Channel drivers
  // ----------------------------------------------------------
  task run_write;
    int cnt;
    int i;
    cnt = 0;
    aw = '{id: id, addr: addr, len: len, burst: burst};
    awvalid = 1'b1;
    while (!awready) next_cycle("AW", cnt);
    next_cycle("AW", cnt);
    awvalid = 1'b0;
    // W opens in the cycle after AW
    check_ready("o_wready", 1'b1, wready);
    for (i = 0; i <= len; i++) begin
      cnt = 0;
      w = '{data: words[i], strb: strb, last: (i == len)};
      wvalid = 1'b1;
      while (!wready) next_cycle("W", cnt);
      next_cycle("W", cnt);
    end
    wvalid = 1'b0;
    // B follows the final W beat by one cycle
    check_ready("o_bvalid", 1'b1, bvalid);
    check_ready("o_wready", 1'b0, wready);
    cnt = 0;
    while (!(bvalid && bready)) next_cycle("B", cnt);
    check_bresp('{id: id, resp: resp}, b);
    next_cycle("B", cnt);
    check_ready("o_awready", 1'b1, awready);
  endtask

  task run_read;
    int cnt;
    int i;
    cnt = 0;
    ar = '{id: id, addr: addr, len: len, burst: burst};
    arvalid = 1'b1;
    while (!arready) next_cycle("AR", cnt);
    next_cycle("AR", cnt);
    arvalid = 1'b0;
    check_ready("o_rvalid", 1'b1, rvalid);
    for (i = 0; i <= len; i++) begin
      cnt = 0;
      while (!(rvalid && rready)) next_cycle("R", cnt);
      check_rbeat('{id: id, data: words[i], resp: resp, last: (i == len)}, r);
      next_cycle("R", cnt);
    end
    // Burst over, channel idle again
    check_ready("o_rvalid", 1'b0, rvalid);
    check_ready("o_arready", 1'b1, arready);
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    rst = 1'b1;
    aw = '0;
    awvalid = 1'b0;
    w = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    ar = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    n_txn = 0;
    repeat (2) @(posedge aclk);
    @(negedge aclk);
    rst = 1'b0;
    check_ready("o_awready", 1'b1, awready);
    check_ready("o_arready", 1'b1, arready);
    check_ready("o_bvalid", 1'b0, bvalid);
    check_ready("o_rvalid", 1'b0, rvalid);

    fd = $fopen("tests/axi_sram_cases.txt", "r");
    if (fd == 0) begin
      abort("could not open the case file");
    end
    while ($fscanf(fd, "%s", kind) == 1) begin
      if (kind == "#") begin
        code = $fgets(line, fd);
      end else begin
        code = $fscanf(fd, "%h %h %h %h %h %h", id, addr, len, burst, strb, resp);
        if (code != 6) begin
          abort("malformed transaction header in the case file");
        end
        for (int i = 0; i <= len; i++) begin
          code = $fscanf(fd, "%h", words[i]);
          if (code != 1) begin
            abort("missing data word in the case file");
          end
        end
        if (kind == "W") begin
          run_write();
        end else if (kind == "R") begin
          run_read();
        end else begin
          abort("unknown transaction kind in the case file");
        end
        n_txn++;
      end
    end
    $fclose(fd);

    if (n_txn == 0) begin
      abort("the case file held no transactions");
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

//--- tests/axi_sram_cases.txt
# kind id addr len burst strb resp, then len+1 hex data words (R lines give expected data)
# burst 0 FIXED 1 INCR 2 WRAP, resp 0 OKAY 2 SLVERR, strb unused on R lines
# single beat, full strobe
W 1 00000000 00 1 ff 0 0123456789abcdef
R 2 00000000 00 1 ff 0 0123456789abcdef
# INCR 4 and 16
W 3 00000100 03 1 ff 0 0f1e2d3c4b5a6978 8796a5b4c3d2e1f0 1357924680aceb0d fedcba9876543210
R 4 00000100 03 1 ff 0 0f1e2d3c4b5a6978 8796a5b4c3d2e1f0 1357924680aceb0d fedcba9876543210
W 5 00000200 0f 1 ff 0 c0de0000beef0000 c0de0000beef0001 c0de0000beef0002 c0de0000beef0003
    c0de0000beef0004 c0de0000beef0005 c0de0000beef0006 c0de0000beef0007
    c0de0000beef0008 c0de0000beef0009 c0de0000beef000a c0de0000beef000b
    c0de0000beef000c c0de0000beef000d c0de0000beef000e c0de0000beef000f
R f 00000200 0f 1 ff 0 c0de0000beef0000 c0de0000beef0001 c0de0000beef0002 c0de0000beef0003
    c0de0000beef0004 c0de0000beef0005 c0de0000beef0006 c0de0000beef0007
    c0de0000beef0008 c0de0000beef0009 c0de0000beef000a c0de0000beef000b
    c0de0000beef000c c0de0000beef000d c0de0000beef000e c0de0000beef000f
# partial strobes merge into words written before
W 6 00000000 00 1 0f 0 5555666677778888
R 7 00000000 00 1 ff 0 0123456777778888
W 8 00000108 00 1 f0 0 aaaabbbbccccdddd
W 9 00000110 00 1 3c 0 ffffffffffffffff
R a 00000100 03 1 ff 0 0f1e2d3c4b5a6978 aaaabbbbc3d2e1f0 1357ffffffffeb0d fedcba9876543210
# FIXED keeps only the last beat
W b 00000300 03 0 ff 0 1111111111111111 2222222222222222 3333333333333333 4444444444444444
R c 00000300 03 0 ff 0 4444444444444444 4444444444444444 4444444444444444 4444444444444444
R d 00000300 00 1 ff 0 4444444444444444
# WRAP is refused, memory unchanged
W e 00000100 03 2 ff 2 deadbeefdeadbeef deadbeefdeadbeef deadbeefdeadbeef deadbeefdeadbeef
R 1 00000100 03 2 ff 2 0000000000000000 0000000000000000 0000000000000000 0000000000000000
R 2 00000100 03 1 ff 0 0f1e2d3c4b5a6978 aaaabbbbc3d2e1f0 1357ffffffffeb0d fedcba9876543210

//--- axi_sram_top.f
hdl/axi_sram_pkg.sv
hdl/sram_bank.sv
hdl/axi_sram_wr_ctrl.sv
hdl/axi_sram_rd_ctrl.sv
hdl/axi_sram_top.sv
tests/tb_axi_sram.sv

//--- Bender.yml
package:
  name: axi_sram

sources:
  - hdl/axi_sram_pkg.sv
  - hdl/sram_bank.sv
  - hdl/axi_sram_wr_ctrl.sv
  - hdl/axi_sram_rd_ctrl.sv
  - hdl/axi_sram_top.sv
  - target: test
    files:
      - tests/tb_axi_sram.sv
